/* Bender.yml */
package:
  name: photon_boundary

sources:
  - files:
      - logic/photon_pkg.sv
      - logic/shared_mult_bank.sv
      - logic/photon_scatterer.sv
      - logic/photon_reflector.sv
      - logic/photon_boundary_top.sv
  - target: test
    files:
      - tests/photon_boundary_props.sv
      - tests/photon_boundary_tb.sv

/* compile.f */
logic/photon_pkg.sv
logic/shared_mult_bank.sv
logic/photon_scatterer.sv
logic/photon_reflector.sv
logic/photon_boundary_top.sv
tests/photon_boundary_props.sv
tests/photon_boundary_tb.sv

/* logic/photon_boundary_top.sv */
// Photon boundary and deflection stage
// Scatterer and reflector side by side, sharing one multiplier bank

`timescale 1ns/1ns
`default_nettype none

module photon_boundary_top #(
	parameter int NUM_LAYERS = 5,
	parameter logic [NUM_LAYERS-1:0][photon_pkg::DIR_W-1:0] N_RATIO_DOWN =
		{NUM_LAYERS{32'h4000_0000}},
	parameter logic [NUM_LAYERS-1:0][photon_pkg::DIR_W-1:0] N_RATIO_UP =
		{NUM_LAYERS{32'h4000_0000}}
) (
	input  wire                                 clock,
	input  wire                                 i_rst_n,
	input  wire                                 i_enable,
	input  wire                                 i_hit,
	input  wire  [photon_pkg::DIR_W-1:0]        i_ux,
	input  wire  [photon_pkg::DIR_W-1:0]        i_uy,
	input  wire  [photon_pkg::DIR_W-1:0]        i_uz,
	input  wire  [photon_pkg::DIR_W-1:0]        i_sinp,
	input  wire  [photon_pkg::DIR_W-1:0]        i_cosp,
	input  wire  [photon_pkg::DIR_W-1:0]        i_rand_azimuth,
	input  wire  [photon_pkg::DIR_W-1:0]        i_rand_fresnel,
	input  wire  [photon_pkg::DIR_W-1:0]        i_up_r_fresnel,
	input  wire  [photon_pkg::DIR_W-1:0]        i_down_r_fresnel,
	input  wire  [photon_pkg::LAYER_W-1:0]      i_layer,
	output logic [photon_pkg::TRIG_INDEX_W-1:0] o_trig_index,
	output logic [photon_pkg::FRES_INDEX_W-1:0] o_fres_index,
	output logic [photon_pkg::DIR_W-1:0]        o_ux_scat,
	output logic [photon_pkg::DIR_W-1:0]        o_uy_scat,
	output logic [photon_pkg::DIR_W-1:0]        o_uz_scat,
	output logic [photon_pkg::DIR_W-1:0]        o_ux_refl,
	output logic [photon_pkg::DIR_W-1:0]        o_uy_refl,
	output logic [photon_pkg::DIR_W-1:0]        o_uz_refl,
	output logic [photon_pkg::LAYER_W-1:0]      o_layer_refl,
	output logic                                o_dead_refl
);

	import photon_pkg::*;

	logic [N_MULT-1:0][DIR_W-1:0]  scat_op_a;
	logic [N_MULT-1:0][DIR_W-1:0]  scat_op_b;
	logic [1:0][DIR_W-1:0]         refl_op_a;
	logic [1:0][DIR_W-1:0]         refl_op_b;
	logic [N_MULT-1:0][PROD_W-1:0] prod;

	//////////////////////////////
	// Deflection paths

	photon_scatterer scat_i (
		.clock          (clock),
		.i_rst_n        (i_rst_n),
		.i_enable       (i_enable),
		.i_ux           (i_ux),
		.i_uy           (i_uy),
		.i_uz           (i_uz),
		.i_layer        (i_layer),
		.i_rand_azimuth (i_rand_azimuth),
		.i_sinp         (i_sinp),
		.i_cosp         (i_cosp),
		.i_prod         (prod),
		.o_trig_index   (o_trig_index),
		.o_op_a         (scat_op_a),
		.o_op_b         (scat_op_b),
		.o_ux           (o_ux_scat),
		.o_uy           (o_uy_scat),
		.o_uz           (o_uz_scat)
	);

	photon_reflector #(
		.NUM_LAYERS   (NUM_LAYERS),
		.N_RATIO_DOWN (N_RATIO_DOWN),
		.N_RATIO_UP   (N_RATIO_UP)
	) refl_i (
		.clock            (clock),
		.i_rst_n          (i_rst_n),
		.i_enable         (i_enable),
		.i_ux             (i_ux),
		.i_uy             (i_uy),
		.i_uz             (i_uz),
		.i_layer          (i_layer),
		.i_rand_fresnel   (i_rand_fresnel),
		.i_up_r_fresnel   (i_up_r_fresnel),
		.i_down_r_fresnel (i_down_r_fresnel),
		.i_prod0          (prod[0]),
		.i_prod1          (prod[1]),
		.o_fres_index     (o_fres_index),
		.o_op_a           (refl_op_a),
		.o_op_b           (refl_op_b),
		.o_ux             (o_ux_refl),
		.o_uy             (o_uy_refl),
		.o_uz             (o_uz_refl),
		.o_layer          (o_layer_refl),
		.o_dead           (o_dead_refl)
	);

	// Hit photons borrow multipliers 0 and 1
	shared_mult_bank bank_i (
		.clock       (clock),
		.i_rst_n     (i_rst_n),
		.i_enable    (i_enable),
		.i_hit       (i_hit),
		.i_scat_op_a (scat_op_a),
		.i_scat_op_b (scat_op_b),
		.i_refl_op_a (refl_op_a),
		.i_refl_op_b (refl_op_b),
		.o_prod      (prod)
	);

endmodule

`default_nettype wire

/* logic/photon_pkg.sv */
// Photon boundary stage shared definitions
// Direction cosines are signed Q1.31 and refractive index ratios signed Q2.30
// One 64-bit product word is read one way by the scatterer and another by the reflector

`default_nettype none

package photon_pkg;

	localparam int DIR_W        = 32;
	localparam int LAYER_W      = 3;
	localparam int AZ_ADDR_W    = 10;
	localparam int TRIG_INDEX_W = LAYER_W + AZ_ADDR_W;
	localparam int FRES_INDEX_W = 10;
	localparam int PROD_W       = 2 * DIR_W;
	localparam int N_MULT       = 4;

	// Fraction bits of each operand kind
	localparam int DIR_FRAC     = 31;
	localparam int RATIO_FRAC   = 30;
	// Magnitude bits kept from a product
	localparam int KEEP_W       = DIR_W - 1;

	//////////////////////////////
	// Product views

	// Q1.31 x Q1.31 with the kept part in bits 61..31
	typedef struct packed {
		logic                                sign;
		logic [PROD_W-KEEP_W-DIR_FRAC-2:0]   redundant;
		logic [KEEP_W-1:0]                   kept;
		logic [DIR_FRAC-1:0]                 low;
	} dir_prod_t;

	// Q1.31 x Q2.30 with the kept part in bits 60..30
	typedef struct packed {
		logic                                sign;
		logic [PROD_W-KEEP_W-RATIO_FRAC-2:0] redundant;
		logic [KEEP_W-1:0]                   kept;
		logic [RATIO_FRAC-1:0]               low;
	} ratio_prod_t;

	typedef union packed {
		dir_prod_t   dir_view;
		ratio_prod_t ratio_view;
	} prod_u;

endpackage

`default_nettype wire

/* logic/photon_reflector.sv */
// Boundary reflector
// Fresnel decision against the reflectance table, then either a mirror of uz
// or a transmission into the neighbouring layer with index-ratio scaling

`timescale 1ns/1ns
`default_nettype none

module photon_reflector #(
	parameter int NUM_LAYERS = 5,
	parameter logic [NUM_LAYERS-1:0][photon_pkg::DIR_W-1:0] N_RATIO_DOWN =
		{NUM_LAYERS{32'h4000_0000}},
	parameter logic [NUM_LAYERS-1:0][photon_pkg::DIR_W-1:0] N_RATIO_UP =
		{NUM_LAYERS{32'h4000_0000}}
) (
	input  wire                                        clock,
	input  wire                                        i_rst_n,
	input  wire                                        i_enable,
	input  wire  [photon_pkg::DIR_W-1:0]               i_ux,
	input  wire  [photon_pkg::DIR_W-1:0]               i_uy,
	input  wire  [photon_pkg::DIR_W-1:0]               i_uz,
	input  wire  [photon_pkg::LAYER_W-1:0]             i_layer,
	input  wire  [photon_pkg::DIR_W-1:0]               i_rand_fresnel,
	input  wire  [photon_pkg::DIR_W-1:0]               i_up_r_fresnel,
	input  wire  [photon_pkg::DIR_W-1:0]               i_down_r_fresnel,
	input  wire  [photon_pkg::PROD_W-1:0]              i_prod0,
	input  wire  [photon_pkg::PROD_W-1:0]              i_prod1,
	output logic [photon_pkg::FRES_INDEX_W-1:0]        o_fres_index,
	output logic [1:0][photon_pkg::DIR_W-1:0]          o_op_a,
	output logic [1:0][photon_pkg::DIR_W-1:0]          o_op_b,
	output logic [photon_pkg::DIR_W-1:0]               o_ux,
	output logic [photon_pkg::DIR_W-1:0]               o_uy,
	output logic [photon_pkg::DIR_W-1:0]               o_uz,
	output logic [photon_pkg::LAYER_W-1:0]             o_layer,
	output logic                                       o_dead
);

	import photon_pkg::*;

	// Layer number just below the deepest tissue layer
	localparam logic [LAYER_W-1:0] LAYER_BELOW = LAYER_W'(NUM_LAYERS + 1);

	logic               going_up;
	logic [DIR_W-1:0]   uz_mag;
	logic [DIR_W-1:0]   r_fresnel;
	logic               reflect;
	logic [LAYER_W-1:0] layer_next;
	logic [DIR_W-1:0]   ratio;
	logic [DIR_W-1:0]   ux_s1;
	logic [DIR_W-1:0]   uy_s1;
	logic [DIR_W-1:0]   uz_s1;
	logic [DIR_W-1:0]   ratio_s1;
	logic               refl_s1;
	logic [LAYER_W-1:0] layer_s1;
	logic [LAYER_W-1:0] layer_next_s1;
	logic [DIR_W-1:0]   ux_s2;
	logic [DIR_W-1:0]   uy_s2;
	logic [DIR_W-1:0]   uz_s2;
	logic               refl_s2;
	logic [LAYER_W-1:0] layer_s2;
	logic [LAYER_W-1:0] layer_next_s2;
	prod_u              prod0_w;
	prod_u              prod1_w;

	//////////////////////////////
	// Fresnel lookup and decision

	assign going_up     = i_uz[DIR_W-1];
	assign uz_mag       = going_up ? -i_uz : i_uz;
	assign o_fres_index = uz_mag[DIR_W-2 -: FRES_INDEX_W];

	assign r_fresnel  = going_up ? i_up_r_fresnel : i_down_r_fresnel;
	assign reflect    = {1'b0, i_rand_fresnel[DIR_W-2:0]} < r_fresnel;
	assign layer_next = going_up ? i_layer - 1'b1 : i_layer + 1'b1;

	// Ratio for the boundary being crossed and zero outside the tissue
	always_comb begin
		ratio = '0;
		if (i_layer != '0 && i_layer <= NUM_LAYERS) begin
			if (going_up)
				ratio = N_RATIO_UP[i_layer - 1'b1];
			else
				ratio = N_RATIO_DOWN[i_layer - 1'b1];
		end
	end

	//////////////////////////////
	// Pipeline stages

	always_ff @(posedge clock) begin
		if (!i_rst_n) begin
			refl_s1       <= 1'b0;
			layer_s1      <= '0;
			layer_next_s1 <= '0;
			refl_s2       <= 1'b0;
			layer_s2      <= '0;
			layer_next_s2 <= '0;
		end else if (i_enable) begin
			refl_s1       <= reflect;
			layer_s1      <= i_layer;
			layer_next_s1 <= layer_next;
			refl_s2       <= refl_s1;
			layer_s2      <= layer_s1;
			layer_next_s2 <= layer_next_s1;
		end
	end

	always_ff @(posedge clock) begin
		if (i_enable) begin
			ux_s1    <= i_ux;
			uy_s1    <= i_uy;
			uz_s1    <= i_uz;
			ratio_s1 <= ratio;
			ux_s2    <= ux_s1;
			uy_s2    <= uy_s1;
			uz_s2    <= uz_s1;
		end
	end

	// ux*ratio and uy*ratio on the two shared multipliers
	assign o_op_a[0] = ux_s1;
	assign o_op_b[0] = ratio_s1;
	assign o_op_a[1] = uy_s1;
	assign o_op_b[1] = ratio_s1;

	assign prod0_w = i_prod0;
	assign prod1_w = i_prod1;

	always_ff @(posedge clock) begin
		if (!i_rst_n) begin
			o_ux    <= '0;
			o_uy    <= '0;
			o_uz    <= '0;
			o_layer <= '0;
			o_dead  <= 1'b0;
		end else if (i_enable) begin
			if (refl_s2) begin
				o_ux    <= ux_s2;
				o_uy    <= uy_s2;
				o_uz    <= -uz_s2;
				o_layer <= layer_s2;
				o_dead  <= 1'b0;
			end else begin
				o_ux    <= {prod0_w.ratio_view.sign, prod0_w.ratio_view.kept};
				o_uy    <= {prod1_w.ratio_view.sign, prod1_w.ratio_view.kept};
				o_uz    <= uz_s2;
				o_layer <= layer_next_s2;
				o_dead  <= (layer_next_s2 == '0) || (layer_next_s2 == LAYER_BELOW);
			end
		end
	end

endmodule

`default_nettype wire

/* logic/photon_scatterer.sv */
// Azimuth scatterer
// Rotates (ux, uy) about the z axis by an angle read from the trig table;
// uz passes through unchanged

`timescale 1ns/1ns
`default_nettype none

module photon_scatterer (
	input  wire                                                   clock,
	input  wire                                                   i_rst_n,
	input  wire                                                   i_enable,
	input  wire  [photon_pkg::DIR_W-1:0]                          i_ux,
	input  wire  [photon_pkg::DIR_W-1:0]                          i_uy,
	input  wire  [photon_pkg::DIR_W-1:0]                          i_uz,
	input  wire  [photon_pkg::LAYER_W-1:0]                        i_layer,
	input  wire  [photon_pkg::DIR_W-1:0]                          i_rand_azimuth,
	input  wire  [photon_pkg::DIR_W-1:0]                          i_sinp,
	input  wire  [photon_pkg::DIR_W-1:0]                          i_cosp,
	input  wire  [photon_pkg::N_MULT-1:0][photon_pkg::PROD_W-1:0] i_prod,
	output logic [photon_pkg::TRIG_INDEX_W-1:0]                   o_trig_index,
	output logic [photon_pkg::N_MULT-1:0][photon_pkg::DIR_W-1:0]  o_op_a,
	output logic [photon_pkg::N_MULT-1:0][photon_pkg::DIR_W-1:0]  o_op_b,
	output logic [photon_pkg::DIR_W-1:0]                          o_ux,
	output logic [photon_pkg::DIR_W-1:0]                          o_uy,
	output logic [photon_pkg::DIR_W-1:0]                          o_uz
);

	import photon_pkg::*;

	logic [LAYER_W-1:0] layer_row;
	logic [DIR_W-1:0]   ux_s1;
	logic [DIR_W-1:0]   uy_s1;
	logic [DIR_W-1:0]   uz_s1;
	logic [DIR_W-1:0]   sinp_s1;
	logic [DIR_W-1:0]   cosp_s1;
	logic [DIR_W-1:0]   uz_s2;
	prod_u [N_MULT-1:0] prod_w;

	// Back to Q1.31 from a direction product
	function automatic logic [DIR_W-1:0] trim_dir(input prod_u p);
		return {p.dir_view.sign, p.dir_view.kept};
	endfunction

	// Layer 0 is outside the tissue and falls back to row 0
	assign layer_row    = (i_layer == '0) ? '0 : i_layer - 1'b1;
	assign o_trig_index = {layer_row, i_rand_azimuth[AZ_ADDR_W-1:0]};

	//////////////////////////////
	// Operand stage

	always_ff @(posedge clock) begin
		if (i_enable) begin
			ux_s1   <= i_ux;
			uy_s1   <= i_uy;
			uz_s1   <= i_uz;
			sinp_s1 <= i_sinp;
			cosp_s1 <= i_cosp;
			// uz waits while the bank multiplies
			uz_s2   <= uz_s1;
		end
	end

	// cosp*ux, sinp*uy, sinp*ux, cosp*uy
	assign o_op_a[0] = cosp_s1;
	assign o_op_b[0] = ux_s1;
	assign o_op_a[1] = sinp_s1;
	assign o_op_b[1] = uy_s1;
	assign o_op_a[2] = sinp_s1;
	assign o_op_b[2] = ux_s1;
	assign o_op_a[3] = cosp_s1;
	assign o_op_b[3] = uy_s1;

	//////////////////////////////
	// Rotation result

	assign prod_w = i_prod;

	always_ff @(posedge clock) begin
		if (!i_rst_n) begin
			o_ux <= '0;
			o_uy <= '0;
			o_uz <= '0;
		end else if (i_enable) begin
			o_ux <= trim_dir(prod_w[0]) - trim_dir(prod_w[1]);
			o_uy <= trim_dir(prod_w[2]) + trim_dir(prod_w[3]);
			o_uz <= uz_s2;
		end
	end

endmodule

`default_nettype wire

/* logic/shared_mult_bank.sv */
// Shared multiplier bank
// Four registered signed 32x32 multipliers; the first two are lent to the
// reflector for photons that hit a boundary, the rest serve the scatterer

`timescale 1ns/1ns
`default_nettype none

module shared_mult_bank (
	input  wire                                                   clock,
	input  wire                                                   i_rst_n,
	input  wire                                                   i_enable,
	input  wire                                                   i_hit,
	input  wire  [photon_pkg::N_MULT-1:0][photon_pkg::DIR_W-1:0]  i_scat_op_a,
	input  wire  [photon_pkg::N_MULT-1:0][photon_pkg::DIR_W-1:0]  i_scat_op_b,
	input  wire  [1:0][photon_pkg::DIR_W-1:0]                     i_refl_op_a,
	input  wire  [1:0][photon_pkg::DIR_W-1:0]                     i_refl_op_b,
	output logic [photon_pkg::N_MULT-1:0][photon_pkg::PROD_W-1:0] o_prod
);

	import photon_pkg::*;

	// Multipliers with switchable owner
	localparam int N_SHARED = 2;

	logic                         hit_q;
	logic [N_MULT-1:0][DIR_W-1:0] op_a;
	logic [N_MULT-1:0][DIR_W-1:0] op_b;

	// Hit follows the photon into the operand stage
	always_ff @(posedge clock) begin
		if (!i_rst_n) begin
			hit_q <= 1'b0;
		end else if (i_enable) begin
			hit_q <= i_hit;
		end
	end

	//////////////////////////////
	// Operand ownership

	always_comb begin
		op_a = i_scat_op_a;
		op_b = i_scat_op_b;
		if (hit_q) begin
			for (int k = 0; k < N_SHARED; k++) begin
				op_a[k] = i_refl_op_a[k];
				op_b[k] = i_refl_op_b[k];
			end
		end
	end

	// Full 64-bit signed products
	always_ff @(posedge clock) begin
		if (i_enable) begin
			for (int k = 0; k < N_MULT; k++) begin
				o_prod[k] <= $signed(op_a[k]) * $signed(op_b[k]);
			end
		end
	end

endmodule

`default_nettype wire

/* tests/photon_boundary_props.sv */
// Reset and hold properties for the photon boundary stage
// Outputs clear under reset and freeze while enable is low

`timescale 1ns/1ns
`default_nettype none

module photon_boundary_props (
	input wire                             clock,
	input wire                             i_rst_n,
	input wire                             i_enable,
	input wire [photon_pkg::DIR_W-1:0]     i_ux_scat,
	input wire [photon_pkg::DIR_W-1:0]     i_uy_scat,
	input wire [photon_pkg::DIR_W-1:0]     i_uz_scat,
	input wire [photon_pkg::DIR_W-1:0]     i_ux_refl,
	input wire [photon_pkg::DIR_W-1:0]     i_uy_refl,
	input wire [photon_pkg::DIR_W-1:0]     i_uz_refl,
	input wire [photon_pkg::LAYER_W-1:0]   i_layer_refl,
	input wire                             i_dead_refl
);

	import photon_pkg::*;

	int unsigned fail_count = 0;

	logic [3*DIR_W-1:0]         scat_out;
	logic [3*DIR_W+LAYER_W:0]   refl_out;

	assign scat_out = {i_ux_scat, i_uy_scat, i_uz_scat};
	assign refl_out = {i_ux_refl, i_uy_refl, i_uz_refl, i_layer_refl, i_dead_refl};

	// Covers every reset edge and the first edge after release
	reset_clears: assert property (@(posedge clock)
			!i_rst_n |=> scat_out == '0 && refl_out == '0)
		else begin
			$error("outputs not cleared by reset");
			fail_count++;
		end

	hold_scat: assert property (@(posedge clock) disable iff (!i_rst_n)
			!i_enable |=> $stable(scat_out))
		else begin
			$error("scatterer outputs changed with enable low");
			fail_count++;
		end

	hold_refl: assert property (@(posedge clock) disable iff (!i_rst_n)
			!i_enable |=> $stable(refl_out))
		else begin
			$error("reflector outputs changed with enable low");
			fail_count++;
		end

endmodule

bind photon_boundary_top photon_boundary_props props_i (
	.clock        (clock),
	.i_rst_n      (i_rst_n),
	.i_enable     (i_enable),
	.i_ux_scat    (o_ux_scat),
	.i_uy_scat    (o_uy_scat),
	.i_uz_scat    (o_uz_scat),
	.i_ux_refl    (o_ux_refl),
	.i_uy_refl    (o_uy_refl),
	.i_uz_refl    (o_uz_refl),
	.i_layer_refl (o_layer_refl),
	.i_dead_refl  (o_dead_refl)
);

`default_nettype wire

/* tests/photon_boundary_tb.sv */
// Photon boundary stage testbench
// Models the trig and Fresnel tables, sends scatter and boundary photons and
// checks every result three enabled edges after its sampling edge

`timescale 1ns/1ns
`default_nettype none

module photon_boundary_tb;

	import photon_pkg::*;

	localparam int NUM_LAYERS = 5;
	// Q2.30 index ratios with entry 0 for layer 1
	localparam logic [NUM_LAYERS-1:0][DIR_W-1:0] RATIO_DOWN =
		{32'h3555_5555, 32'h4666_6666, 32'h3000_0000, 32'h5555_5555, 32'h3999_9999};
	localparam logic [NUM_LAYERS-1:0][DIR_W-1:0] RATIO_UP =
		{32'h4ccc_cccd, 32'h3800_0000, 32'h5000_0000, 32'h3333_3333, 32'h4400_0000};
	localparam int N_PHOTONS   = 67;
	localparam int WATCHDOG_NS = (N_PHOTONS + 40) * 20 * 2;
	localparam int BUBBLE      = 0;
	localparam int SCATTER     = 1;
	localparam int BOUNDARY    = 2;

	typedef struct {
		int                 kind;
		string              test;
		logic [DIR_W-1:0]   ux;
		logic [DIR_W-1:0]   uy;
		logic [DIR_W-1:0]   uz;
		logic [LAYER_W-1:0] layer;
		logic               dead;
	} expect_t;

	logic                      clock, i_rst_n, i_enable, i_hit;
	logic [DIR_W-1:0]          i_ux, i_uy, i_uz, i_sinp, i_cosp;
	logic [DIR_W-1:0]          i_rand_azimuth, i_rand_fresnel;
	logic [DIR_W-1:0]          i_up_r_fresnel, i_down_r_fresnel;
	logic [LAYER_W-1:0]        i_layer, o_layer_refl;
	logic [TRIG_INDEX_W-1:0]   o_trig_index;
	logic [FRES_INDEX_W-1:0]   o_fres_index;
	logic [DIR_W-1:0]          o_ux_scat, o_uy_scat, o_uz_scat;
	logic [DIR_W-1:0]          o_ux_refl, o_uy_refl, o_uz_refl;
	logic                      o_dead_refl;
	logic [DIR_W-1:0]          sin_tab [1<<TRIG_INDEX_W];
	logic [DIR_W-1:0]          cos_tab [1<<TRIG_INDEX_W];
	expect_t                   pending [$];
	expect_t                   bubble;
	integer                    seed;
	int                        checks;
	int                        errors;

	photon_boundary_top #(
		.NUM_LAYERS   (NUM_LAYERS),
		.N_RATIO_DOWN (RATIO_DOWN),
		.N_RATIO_UP   (RATIO_UP)
	) dut_i (.*);

	always #10 clock = ~clock;

	//////////////////////////////
	// Table models

	function automatic logic [DIR_W-1:0] up_reflectance(input logic [FRES_INDEX_W-1:0] idx);
		return {1'b0, idx ^ 10'h2a5, 21'h0a5a5};
	endfunction

	function automatic logic [DIR_W-1:0] down_reflectance(input logic [FRES_INDEX_W-1:0] idx);
		return {1'b0, ~idx, 21'h15a5a};
	endfunction

	assign i_sinp           = sin_tab[o_trig_index];
	assign i_cosp           = cos_tab[o_trig_index];
	assign i_up_r_fresnel   = up_reflectance(o_fres_index);
	assign i_down_r_fresnel = down_reflectance(o_fres_index);

	//////////////////////////////
	// Reference arithmetic

	// Q1.31 x Q1.31 back to Q1.31
	function automatic logic [DIR_W-1:0] mul_dir(input logic [DIR_W-1:0] a,
			input logic [DIR_W-1:0] b);
		logic signed [PROD_W-1:0] p;
		p = $signed(a) * $signed(b);
		return {p[63], p[61:31]};
	endfunction

	// Q1.31 x Q2.30 back to Q1.31
	function automatic logic [DIR_W-1:0] mul_ratio(input logic [DIR_W-1:0] a,
			input logic [DIR_W-1:0] b);
		logic signed [PROD_W-1:0] p;
		p = $signed(a) * $signed(b);
		return {p[63], p[60:30]};
	endfunction

	function automatic int rand_below(input int n);
		return $unsigned($random(seed)) % n;
	endfunction

	//////////////////////////////
	// Checking

	task automatic check_word(input string test, input string field,
			input logic [DIR_W-1:0] exp, input logic [DIR_W-1:0] act);
		checks++;
		assert (act === exp) else begin
			$display("** Error %s %s: expected %h, actual %h", test, field, exp, act);
			errors++;
		end
	endtask

	task automatic check_front();
		expect_t e;
		e = pending.pop_front();
		if (e.kind == SCATTER) begin
			check_word(e.test, "ux scat", e.ux, o_ux_scat);
			check_word(e.test, "uy scat", e.uy, o_uy_scat);
			check_word(e.test, "uz scat", e.uz, o_uz_scat);
		end else if (e.kind == BOUNDARY) begin
			check_word(e.test, "ux refl", e.ux, o_ux_refl);
			check_word(e.test, "uy refl", e.uy, o_uy_refl);
			check_word(e.test, "uz refl", e.uz, o_uz_refl);
			check_word(e.test, "layer refl", e.layer, o_layer_refl);
			check_word(e.test, "dead refl", e.dead, o_dead_refl);
		end
	endtask

	// The oldest photon is out after its third enabled edge
	task automatic advance(input logic en, input expect_t e);
		@(negedge clock);
		if (i_enable && pending.size() == 3)
			check_front();
		i_enable = en;
		if (en)
			pending.push_back(e);
	endtask

	//////////////////////////////
	// Photon stimulus

	task automatic send_scatter(input string test, input logic [LAYER_W-1:0] layer);
		expect_t                 e;
		logic [DIR_W-1:0]        ux;
		logic [DIR_W-1:0]        uy;
		logic [DIR_W-1:0]        uz;
		logic [DIR_W-1:0]        az;
		logic [LAYER_W-1:0]      row;
		logic [TRIG_INDEX_W-1:0] idx;
		ux = $random(seed);
		uy = $random(seed);
		uz = $random(seed);
		az = $random(seed);
		row = (layer == '0) ? '0 : layer - 3'd1;
		idx = {row, az[AZ_ADDR_W-1:0]};
		e.kind = SCATTER;
		e.test = test;
		e.ux = mul_dir(cos_tab[idx], ux) - mul_dir(sin_tab[idx], uy);
		e.uy = mul_dir(sin_tab[idx], ux) + mul_dir(cos_tab[idx], uy);
		e.uz = uz;
		advance(1'b1, e);
		i_hit = 1'b0;
		i_ux = ux;
		i_uy = uy;
		i_uz = uz;
		i_layer = layer;
		i_rand_azimuth = az;
		i_rand_fresnel = $random(seed);
		#1;
		check_word(test, "trig index", idx, o_trig_index);
	endtask

	task automatic send_boundary(input string test, input logic [LAYER_W-1:0] layer,
			input logic up, input logic refl);
		expect_t                 e;
		logic [DIR_W-1:0]        ux;
		logic [DIR_W-1:0]        uy;
		logic [DIR_W-1:0]        uz;
		logic [DIR_W-1:0]        mag;
		logic [DIR_W-1:0]        r;
		logic [DIR_W-1:0]        rnd;
		logic [DIR_W-1:0]        ratio;
		logic [LAYER_W-1:0]      next;
		logic [FRES_INDEX_W-1:0] fidx;
		ux = $random(seed);
		uy = $random(seed);
		uz = $random(seed);
		uz[DIR_W-1] = up;
		mag = up ? -uz : uz;
		fidx = mag[30:21];
		r = up ? up_reflectance(fidx) : down_reflectance(fidx);
		// Strictly below the reflectance reflects and at or above it transmits
		if (refl)
			rnd = r - 32'd1 - ($random(seed) & 32'h0fff);
		else
			rnd = r + ($random(seed) & 32'h0003);
		rnd[DIR_W-1] = 1'(rand_below(2));
		ratio = up ? RATIO_UP[layer - 1] : RATIO_DOWN[layer - 1];
		next = up ? layer - 3'd1 : layer + 3'd1;
		e.kind = BOUNDARY;
		e.test = test;
		e.dead = 1'b0;
		if (refl) begin
			e.ux = ux;
			e.uy = uy;
			e.uz = -uz;
			e.layer = layer;
		end else begin
			e.ux = mul_ratio(ux, ratio);
			e.uy = mul_ratio(uy, ratio);
			e.uz = uz;
			e.layer = next;
			e.dead = (next == 3'd0) || (next == LAYER_W'(NUM_LAYERS + 1));
		end
		advance(1'b1, e);
		i_hit = 1'b1;
		i_ux = ux;
		i_uy = uy;
		i_uz = uz;
		i_layer = layer;
		i_rand_fresnel = rnd;
		i_rand_azimuth = $random(seed);
		#1;
		check_word(test, "fresnel index", fidx, o_fres_index);
	endtask

	// Enable low while the inputs wander
	task automatic stall(input int n);
		repeat (n) begin
			advance(1'b0, bubble);
			i_ux = $random(seed);
			i_uz = $random(seed);
			i_hit = 1'(rand_below(2));
		end
	endtask

	initial begin
		seed = 46;
		checks = 0;
		errors = 0;
		bubble.kind = BUBBLE;
		clock = 1'b0;
		i_rst_n = 1'b0;
		i_enable = 1'b0;
		i_hit = 1'b0;
		i_ux = '0;
		i_uy = '0;
		i_uz = '0;
		i_layer = '0;
		i_rand_azimuth = '0;
		i_rand_fresnel = '0;
		for (int k = 0; k < (1 << TRIG_INDEX_W); k++) begin
			sin_tab[k] = $random(seed);
			cos_tab[k] = $random(seed);
		end
		repeat (16) @(negedge clock);
		i_rst_n = 1'b1;

		repeat (16) send_scatter("azimuth", LAYER_W'(rand_below(6)));
		// Bank ownership flips per photon
		for (int k = 0; k < 12; k++) begin
			send_scatter("interleave", LAYER_W'(rand_below(6)));
			send_boundary("interleave", LAYER_W'(rand_below(5) + 1), 1'(rand_below(2)),
				1'(rand_below(2)));
		end
		for (int l = 1; l <= NUM_LAYERS; l++) begin
			send_boundary((l == 1) ? "exit" : "transmit", LAYER_W'(l), 1'b1, 1'b0);
			send_boundary((l == NUM_LAYERS) ? "exit" : "transmit", LAYER_W'(l), 1'b0, 1'b0);
		end
		for (int l = 1; l <= NUM_LAYERS; l++)
			send_boundary("reflect", LAYER_W'(l), 1'(l % 2), 1'b1);
		for (int k = 0; k < 12; k++) begin
			if (k % 2 == 0)
				send_scatter("hold", LAYER_W'(rand_below(6)));
			else
				send_boundary("hold", LAYER_W'(rand_below(5) + 1), 1'(rand_below(2)),
					1'(rand_below(2)));
			stall(rand_below(4));
		end
		repeat (3) advance(1'b1, bubble);

		$display("Checks: %0d, errors: %0d, property failures: %0d",
			checks, errors, dut_i.props_i.fail_count);
		if (checks > 0 && errors == 0 && dut_i.props_i.fail_count == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

	// Watchdog
	initial begin
		#(WATCHDOG_NS);
		$display("Timeout: the photon sequence did not finish in time");
		$display("=== FAIL ===");
		$finish;
	end

endmodule

`default_nettype wire
